//--- Makefile
# Verilator simulation of the decode and issue stage

TOP = decode_issue_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --top-module $(TOP) -f project.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- bench/decode_issue_tb.sv
/*
 * Testbench for the decode and issue stage
 * Random instructions, readies and writebacks from a fixed seed,
 * checked every cycle against a register file and scoreboard model
 */

`timescale 1ns/1ns
`include "decode_macros.svh"

module decode_issue_tb import decode_pkg::*; ();

    localparam int NUM_INSTR = 2000;
    localparam int CYCLES_PER_INSTR = 20;
    localparam int MAX_CYCLES = NUM_INSTR * CYCLES_PER_INSTR;
    localparam int B_ISSUE = 0;
    localparam int B_HAZARD = 1;
    localparam int B_ALU = 2;
    localparam int B_LS = 3;
    localparam int B_BRSYS = 4;
    localparam int B_ILLEGAL = 5;
    localparam int NUM_B = 6;

    logic clk = 1'b0;
    logic rst;
    logic fetch_valid;
    logic [`XLEN-1:0] fetch_pc, fetch_instruction;
    logic fetch_pop;
    logic branch_ready, alu_ready, ls_ready, gc_ready;
    logic branch_issue, alu_issue, ls_issue, gc_issue;
    logic wb_valid;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0] wb_data;
    logic gc_issue_hold, gc_fetch_flush;
    logic illegal_instruction, gc_flush_required;
    logic [`ALU_OPERAND_W-1:0] alu_in1, alu_in2;
    logic [4:0] shift_amount;
    logic alu_subtract, alu_arith_shift, alu_left_shift;
    logic [2:0] alu_fn3, ls_fn3, branch_fn3;
    logic [`XLEN-1:0] ls_base, store_data, branch_rs1, branch_rs2, branch_pc, gc_rs1;
    logic [11:0] ls_offset;
    logic ls_load, ls_store;
    logic branch_signed, branch_jal, branch_jalr;
    gc_op_t gc_op;

    // Model state
    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic [`REG_COUNT-1:0] pending;

    // Expected decode of the presented instruction
    logic [`REG_ADDR_W-1:0] e_rs1, e_rs2, e_rd;
    logic e_uses_rs1, e_uses_rs2, e_uses_rd, e_illegal;
    unit_t e_unit;
    gc_op_t e_gc;
    logic [`NUM_UNITS-1:0] exp_strobe;
    logic exp_pop, exp_illegal, exp_conflict;

    int checks [NUM_B];
    int errors [NUM_B];
    string names [NUM_B] = '{"issue rule", "hazards and register data", "ALU operands",
                             "load/store", "branch and system", "illegal instructions"};
    int cycle, presented, popped, illegal_popped, hazard_stalls, total_errors;
    logic timed_out;

    decode_issue_top dut (.*);

    always #5 clk = ~clk;

    ////////////////////
    // Reference decode

    function automatic logic is_base_opcode(input logic [4:0] op);
        return opcode_t'(op) inside {LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE,
                                     ARITH, ARITH_IMM, FENCE, SYSTEM};
    endfunction

    task automatic decode_model(input logic [`XLEN-1:0] ins);
        opcode_t op;
        logic [2:0] f3;
        logic [2:0] use_mask;
        op = opcode_t'(ins[6:2]);
        f3 = ins[14:12];
        e_rs1 = ins[19:15];
        e_rs2 = ins[24:20];
        e_rd = ins[11:7];
        e_illegal = !is_base_opcode(ins[6:2]) || (ins[1:0] != 2'b11) ||
                    (op == ARITH && ins[25]);
        // rs1, rs2, rd by instruction format
        case (op)
            ARITH:                 use_mask = 3'b111;
            ARITH_IMM, LOAD, JALR: use_mask = 3'b101;
            BRANCH, STORE:         use_mask = 3'b110;
            LUI, AUIPC, JAL:       use_mask = 3'b001;
            SYSTEM:                use_mask = (f3 == 3'b000) ? 3'b000 : {~f3[2], 2'b01};
            default:               use_mask = 3'b000;
        endcase
        if (e_illegal)
            use_mask = 3'b000;
        {e_uses_rs1, e_uses_rs2, e_uses_rd} = use_mask;
        case (op)
            BRANCH, JAL, JALR: e_unit = UNIT_BRANCH;
            LOAD, STORE:       e_unit = UNIT_LS;
            SYSTEM, FENCE:     e_unit = UNIT_GC;
            default:           e_unit = UNIT_ALU;
        endcase
        e_gc = GC_NONE;
        if (op == FENCE) begin
            e_gc = f3[0] ? GC_IFENCE : GC_FENCE;
        end else if (op == SYSTEM && f3 != 3'b000) begin
            e_gc = GC_CSR;
        end else if (op == SYSTEM) begin
            case (ins[21:20])
                2'b00:   e_gc = GC_ECALL;
                2'b01:   e_gc = GC_EBREAK;
                2'b10:   e_gc = GC_RET;
                default: e_gc = GC_NONE;
            endcase
        end
    endtask

    task automatic report_error(input int b, input string name, input string values);
        $display("MISMATCH at time %0t: %s is %s", $time, name, values);
        errors[b]++;
    endtask

    ////////////////////
    // Checks at the falling edge

    task automatic check_outputs();
        logic [`XLEN-1:0] ins;
        logic [`XLEN-1:0] op1;
        logic [`XLEN-1:0] op2;
        logic [`ALU_OPERAND_W-1:0] e_in1;
        logic [`ALU_OPERAND_W-1:0] e_in2;
        logic [4:0] e_shamt;
        logic [11:0] e_offset;
        logic [`NUM_UNITS-1:0] ready;
        logic [`NUM_UNITS-1:0] strobe;
        logic [2:0] f3;
        logic allowed;
        logic e_flush;
        opcode_t op;
        ins = fetch_instruction;
        decode_model(ins);
        op = opcode_t'(ins[6:2]);
        f3 = ins[14:12];
        exp_conflict = (e_uses_rs1 && pending[e_rs1]) || (e_uses_rs2 && pending[e_rs2]);
        allowed = fetch_valid && !gc_issue_hold && !gc_fetch_flush && !exp_conflict;
        ready = {gc_ready, ls_ready, alu_ready, branch_ready};
        exp_strobe = '0;
        if (allowed && !e_illegal && ready[e_unit])
            exp_strobe[e_unit] = 1'b1;
        exp_illegal = allowed && e_illegal;
        exp_pop = (|exp_strobe) || exp_illegal;
        strobe = {gc_issue, ls_issue, alu_issue, branch_issue};

        checks[B_ISSUE]++;
        if (fetch_pop !== exp_pop)
            report_error(B_ISSUE, "fetch_pop",
                         $sformatf("%b, expected %b", fetch_pop, exp_pop));
        if (strobe !== exp_strobe)
            report_error(B_ISSUE, "issue strobes",
                         $sformatf("%b, expected %b", strobe, exp_strobe));

        if (fetch_valid && exp_conflict)
            hazard_stalls++;
        // Source data reaches every unit port
        if (exp_strobe[UNIT_LS] || exp_strobe[UNIT_BRANCH] || exp_strobe[UNIT_GC]) begin
            checks[B_HAZARD]++;
            if (ls_base !== regs[e_rs1])
                report_error(B_HAZARD, "ls_base",
                             $sformatf("%h, expected %h", ls_base, regs[e_rs1]));
            if (branch_rs1 !== regs[e_rs1])
                report_error(B_HAZARD, "branch_rs1",
                             $sformatf("%h, expected %h", branch_rs1, regs[e_rs1]));
            if (gc_rs1 !== regs[e_rs1])
                report_error(B_HAZARD, "gc_rs1",
                             $sformatf("%h, expected %h", gc_rs1, regs[e_rs1]));
            if (store_data !== regs[e_rs2])
                report_error(B_HAZARD, "store_data",
                             $sformatf("%h, expected %h", store_data, regs[e_rs2]));
            if (branch_rs2 !== regs[e_rs2])
                report_error(B_HAZARD, "branch_rs2",
                             $sformatf("%h, expected %h", branch_rs2, regs[e_rs2]));
        end

        if (exp_strobe[UNIT_ALU]) begin
            case (op)
                LUI:     op1 = '0;
                AUIPC:   op1 = fetch_pc;
                default: op1 = regs[e_rs1];
            endcase
            case (op)
                LUI, AUIPC: op2 = {ins[31:12], 12'b0};
                ARITH_IMM:  op2 = {{(`XLEN-12){ins[31]}}, ins[31:20]};
                default:    op2 = regs[e_rs2];
            endcase
            e_in1 = {op1[`XLEN-1] & ~f3[0], op1};
            e_in2 = {op2[`XLEN-1] & ~f3[0], op2};
            e_shamt = (op == ARITH) ? regs[e_rs2][4:0] : ins[24:20];
            checks[B_ALU]++;
            if (alu_in1 !== e_in1)
                report_error(B_ALU, "alu_in1", $sformatf("%h, expected %h", alu_in1, e_in1));
            if (alu_in2 !== e_in2)
                report_error(B_ALU, "alu_in2", $sformatf("%h, expected %h", alu_in2, e_in2));
            if (shift_amount !== e_shamt)
                report_error(B_ALU, "shift_amount",
                             $sformatf("%h, expected %h", shift_amount, e_shamt));
            if (alu_subtract !== (op == ARITH && ins[30]))
                report_error(B_ALU, "alu_subtract", $sformatf("%b, expected %b",
                             alu_subtract, op == ARITH && ins[30]));
            if (alu_arith_shift !== (ins[30] & op1[`XLEN-1]))
                report_error(B_ALU, "alu_arith_shift", $sformatf("%b, expected %b",
                             alu_arith_shift, ins[30] & op1[`XLEN-1]));
            if (alu_left_shift !== ~f3[2])
                report_error(B_ALU, "alu_left_shift", $sformatf("%b, expected %b",
                             alu_left_shift, ~f3[2]));
            if (alu_fn3 !== f3)
                report_error(B_ALU, "alu_fn3", $sformatf("%h, expected %h", alu_fn3, f3));
        end

        if (exp_strobe[UNIT_LS]) begin
            e_offset = (op == STORE) ? {ins[31:25], ins[11:7]} : ins[31:20];
            checks[B_LS]++;
            if (ls_offset !== e_offset)
                report_error(B_LS, "ls_offset",
                             $sformatf("%h, expected %h", ls_offset, e_offset));
            if (ls_load !== (op == LOAD) || ls_store !== (op == STORE))
                report_error(B_LS, "ls_load/ls_store", $sformatf("%b%b, expected %b%b",
                             ls_load, ls_store, op == LOAD, op == STORE));
            if (ls_fn3 !== f3)
                report_error(B_LS, "ls_fn3", $sformatf("%h, expected %h", ls_fn3, f3));
        end

        e_flush = exp_strobe[UNIT_GC] && (e_gc inside {GC_ECALL, GC_EBREAK, GC_RET, GC_IFENCE});
        checks[B_BRSYS]++;
        if (gc_flush_required !== e_flush)
            report_error(B_BRSYS, "gc_flush_required",
                         $sformatf("%b, expected %b", gc_flush_required, e_flush));
        if (exp_strobe[UNIT_BRANCH] && {branch_jal, branch_jalr, branch_signed} !==
                {op == JAL, op == JALR, !(f3 inside {3'b110, 3'b111})})
            report_error(B_BRSYS, "branch_jal/jalr/signed", $sformatf("%b%b%b, expected %b%b%b",
                         branch_jal, branch_jalr, branch_signed, op == JAL, op == JALR,
                         !(f3 inside {3'b110, 3'b111})));
        if (exp_strobe[UNIT_BRANCH]) begin
            if (branch_fn3 !== f3)
                report_error(B_BRSYS, "branch_fn3",
                             $sformatf("%h, expected %h", branch_fn3, f3));
            if (branch_pc !== fetch_pc)
                report_error(B_BRSYS, "branch_pc",
                             $sformatf("%h, expected %h", branch_pc, fetch_pc));
        end
        if (exp_strobe[UNIT_GC] && gc_op !== e_gc)
            report_error(B_BRSYS, "gc_op",
                         $sformatf("%s, expected %s", gc_op.name(), e_gc.name()));

        if (exp_illegal) begin
            illegal_popped++;
            checks[B_ILLEGAL]++;
            if (illegal_instruction !== 1'b1 || strobe !== '0)
                report_error(B_ILLEGAL, "illegal_instruction/issue strobes",
                             $sformatf("%b/%b, expected 1/0000", illegal_instruction, strobe));
        end else if (illegal_instruction !== 1'b0) begin
            report_error(B_ILLEGAL, "illegal_instruction",
                         $sformatf("%b, expected 0", illegal_instruction));
        end
    endtask

    ////////////////////
    // Model update and stimulus at the rising edge

    task automatic update_model();
        if (wb_valid) begin
            if (wb_rd != '0)
                regs[wb_rd] = wb_data;
            pending[wb_rd] = 1'b0;
        end
        // Set wins over a writeback to the same register
        if ((|exp_strobe) && e_uses_rd && e_rd != '0)
            pending[e_rd] = 1'b1;
        if (exp_pop)
            popped++;
    endtask

    function automatic logic [`XLEN-1:0] random_instruction();
        logic [`XLEN-1:0] ins;
        int kind;
        ins = $urandom;
        // Legal below 90, then unknown opcode, M extension op, bad low bits
        kind = $urandom % 100;
        do begin
            ins[6:2] = 5'($urandom);
        end while (is_base_opcode(ins[6:2]) == (kind >= 90 && kind < 94));
        ins[1:0] = 2'b11;
        if (kind < 90 && ins[6:2] == ARITH)
            ins[25] = 1'b0;
        if (kind >= 94 && kind < 97) begin
            ins[6:2] = ARITH;
            ins[25] = 1'b1;
        end
        if (kind >= 97)
            ins[1:0] = 2'($urandom % 3);
        return ins;
    endfunction

    task automatic drive_inputs();
        int pend_q[$];
        if (exp_pop || !fetch_valid) begin
            if (presented < NUM_INSTR && ($urandom % 10) != 0) begin
                fetch_valid <= 1'b1;
                fetch_instruction <= random_instruction();
                fetch_pc <= $urandom & 32'hffff_fffc;
                presented++;
            end else begin
                fetch_valid <= 1'b0;
            end
        end
        branch_ready <= ($urandom % 4) != 0;
        alu_ready <= ($urandom % 4) != 0;
        ls_ready <= ($urandom % 4) != 0;
        gc_ready <= ($urandom % 4) != 0;
        gc_issue_hold <= ($urandom % 25) == 0;
        gc_fetch_flush <= ($urandom % 25) == 0;
        // Writebacks only for registers the model has pending
        for (int r = 1; r < `REG_COUNT; r++) begin
            if (pending[r])
                pend_q.push_back(r);
        end
        if (pend_q.size() > 0 && ($urandom % 10) < 7) begin
            wb_valid <= 1'b1;
            wb_rd <= 5'(pend_q[$urandom % pend_q.size()]);
            wb_data <= $urandom;
        end else begin
            wb_valid <= 1'b0;
        end
    endtask

    initial begin
        void'($urandom(30049));
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        fetch_instruction = '0;
        {branch_ready, alu_ready, ls_ready, gc_ready} = '0;
        wb_valid = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        gc_issue_hold = 1'b0;
        gc_fetch_flush = 1'b0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            regs[r] = '0;
        end
        pending = '0;
        timed_out = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        while (popped < NUM_INSTR && cycle < MAX_CYCLES) begin
            @(negedge clk);
            check_outputs();
            @(posedge clk);
            update_model();
            drive_inputs();
            cycle++;
        end
        if (cycle >= MAX_CYCLES) begin
            timed_out = 1'b1;
            $display("Timeout: only %0d of %0d instructions popped in %0d cycles",
                     popped, NUM_INSTR, cycle);
        end

        for (int b = 0; b < NUM_B; b++) begin
            $display("%s: %0d checks, %0d errors", names[b], checks[b], errors[b]);
            total_errors += errors[b];
        end
        $display("%0d instructions popped, %0d illegal, %0d hazard stalls, %0d cycles, %0d errors",
                 popped, illegal_popped, hazard_stalls, cycle, total_errors);
        if (total_errors == 0 && !timed_out)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- include/decode_macros.svh
/*
 * Width and count macros for the decode and issue stage
 * Data width, register addressing, unit count, ALU operand width
 */

`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Data path
`define XLEN 32

// Register file addressing
`define REG_ADDR_W 5
`define REG_COUNT 32

// Branch, ALU, load/store and global control
`define NUM_UNITS 4

// XLEN plus the compare sign bit
`define ALU_OPERAND_W 33

`endif

//--- project.f
+incdir+include
source/decode_pkg.sv
source/instruction_decoder.sv
source/register_file.sv
source/register_scoreboard.sv
source/issue_control.sv
source/alu_operand_select.sv
source/decode_issue_top.sv
bench/decode_issue_tb.sv

//--- source/alu_operand_select.sv
/*
 * ALU operand selection
 * Operand muxes with immediates, compare sign bit, shift controls
 */

`timescale 1ns/1ns
`include "decode_macros.svh"

module alu_operand_select import decode_pkg::*; (
    input  logic [`XLEN-1:0]          instruction,
    input  logic [`XLEN-1:0]          fetch_pc,
    input  logic [`XLEN-1:0]          rs1_data,
    input  logic [`XLEN-1:0]          rs2_data,
    input  alu_rs1_sel_t              alu_rs1_sel,
    input  alu_rs2_sel_t              alu_rs2_sel,
    output logic [`ALU_OPERAND_W-1:0] alu_in1,
    output logic [`ALU_OPERAND_W-1:0] alu_in2,
    output logic [4:0]                shift_amount,
    output logic                      alu_subtract,
    output logic                      alu_arith_shift,
    output logic                      alu_left_shift,
    output logic [2:0]                alu_fn3
);

    logic [`XLEN-1:0] operand1;
    logic [`XLEN-1:0] operand2;
    logic register_op;

    assign register_op = (opcode_t'(instruction[6:2]) == ARITH);
    assign alu_fn3 = instruction[14:12];

    always_comb begin
        case (alu_rs1_sel)
            RS1_ZERO: operand1 = '0;
            RS1_PC:   operand1 = fetch_pc;
            default:  operand1 = rs1_data;
        endcase
        case (alu_rs2_sel)
            RS2_UPPER_IMM: operand2 = {instruction[31:12], 12'b0};
            RS2_ARITH_IMM: operand2 = {{(`XLEN-12){instruction[31]}}, instruction[31:20]};
            RS2_LINK_FOUR: operand2 = `XLEN'(4);
            default:       operand2 = rs2_data;
        endcase
    end

    // Sign extension for set-less-than, cleared for the unsigned forms
    assign alu_in1 = {operand1[`XLEN-1] & ~alu_fn3[0], operand1};
    assign alu_in2 = {operand2[`XLEN-1] & ~alu_fn3[0], operand2};

    ////////////////////
    // Shifter and adder controls
    assign shift_amount = register_op ? rs2_data[4:0] : instruction[24:20];
    assign alu_subtract = register_op && instruction[30];
    // Bit shifted in on SRA and SRAI
    assign alu_arith_shift = instruction[30] && operand1[`XLEN-1];
    assign alu_left_shift = ~alu_fn3[2];

endmodule

//--- source/decode_issue_top.sv
/*
 * Decode and issue stage top level
 * Decoder, register file, scoreboard, issue control, ALU operand select
 */

`timescale 1ns/1ns
`include "decode_macros.svh"

module decode_issue_top import decode_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    // Fetch
    input  logic                      fetch_valid,
    input  logic [`XLEN-1:0]          fetch_pc,
    input  logic [`XLEN-1:0]          fetch_instruction,
    output logic                      fetch_pop,
    // Unit handshake
    input  logic                      branch_ready,
    input  logic                      alu_ready,
    input  logic                      ls_ready,
    input  logic                      gc_ready,
    output logic                      branch_issue,
    output logic                      alu_issue,
    output logic                      ls_issue,
    output logic                      gc_issue,
    // Writeback
    input  logic                      wb_valid,
    input  logic [`REG_ADDR_W-1:0]    wb_rd,
    input  logic [`XLEN-1:0]          wb_data,
    // Global control
    input  logic                      gc_issue_hold,
    input  logic                      gc_fetch_flush,
    output logic                      illegal_instruction,
    output logic                      gc_flush_required,
    // ALU
    output logic [`ALU_OPERAND_W-1:0] alu_in1,
    output logic [`ALU_OPERAND_W-1:0] alu_in2,
    output logic [4:0]                shift_amount,
    output logic                      alu_subtract,
    output logic                      alu_arith_shift,
    output logic                      alu_left_shift,
    output logic [2:0]                alu_fn3,
    // Load/store
    output logic [`XLEN-1:0]          ls_base,
    output logic [11:0]               ls_offset,
    output logic [2:0]                ls_fn3,
    output logic                      ls_load,
    output logic                      ls_store,
    output logic [`XLEN-1:0]          store_data,
    // Branch
    output logic [`XLEN-1:0]          branch_rs1,
    output logic [`XLEN-1:0]          branch_rs2,
    output logic [2:0]                branch_fn3,
    output logic                      branch_signed,
    output logic                      branch_jal,
    output logic                      branch_jalr,
    output logic [`XLEN-1:0]          branch_pc,
    // Global control unit
    output gc_op_t                    gc_op,
    output logic [`XLEN-1:0]          gc_rs1
);

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;
    logic [`NUM_UNITS-1:0] unit_request;
    logic illegal;
    alu_rs1_sel_t alu_rs1_sel;
    alu_rs2_sel_t alu_rs2_sel;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic rs1_conflict;
    logic rs2_conflict;
    logic set_valid;
    logic [`REG_ADDR_W-1:0] set_rd;

    instruction_decoder decoder (
        .instruction(fetch_instruction),
        .*
    );

    register_file regfile (.*);

    register_scoreboard scoreboard (.*);

    issue_control issue (.*);

    alu_operand_select alu_select (
        .instruction(fetch_instruction),
        .*
    );

    ////////////////////
    // Unit operands from the register file
    assign ls_base = rs1_data;
    assign store_data = rs2_data;
    assign branch_rs1 = rs1_data;
    assign branch_rs2 = rs2_data;
    assign branch_pc = fetch_pc;
    assign gc_rs1 = rs1_data;

endmodule

//--- source/decode_pkg.sv
/*
 * Shared types of the decode and issue stage
 * Trimmed opcodes, unit indices, ALU operand selects, system ops
 */

package decode_pkg;

    // Instruction bits 6 to 2 of the base integer ISA
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        FENCE     = 5'b00011,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_t;

    // Bit positions in the unit request and ready vectors
    typedef enum logic [1:0] {
        UNIT_BRANCH = 2'd0,
        UNIT_ALU    = 2'd1,
        UNIT_LS     = 2'd2,
        UNIT_GC     = 2'd3
    } unit_t;

    typedef enum logic [1:0] {
        RS1_ZERO,
        RS1_PC,
        RS1_REG
    } alu_rs1_sel_t;

    typedef enum logic [1:0] {
        RS2_UPPER_IMM,
        RS2_ARITH_IMM,
        RS2_LINK_FOUR,
        RS2_REG
    } alu_rs2_sel_t;

    // Global control operations
    typedef enum logic [2:0] {
        GC_NONE,
        GC_FENCE,
        GC_IFENCE,
        GC_CSR,
        GC_ECALL,
        GC_EBREAK,
        GC_RET
    } gc_op_t;

endpackage

//--- source/instruction_decoder.sv
/*
 * Instruction decoder
 * Field slicing, unit selection, illegal opcode detection,
 * ALU operand selects, load/store, branch and system decode
 */

`timescale 1ns/1ns
`include "decode_macros.svh"

module instruction_decoder import decode_pkg::*; (
    input  logic [`XLEN-1:0]       instruction,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`REG_ADDR_W-1:0] rd_addr,
    output logic                   uses_rs1,
    output logic                   uses_rs2,
    output logic                   uses_rd,
    output logic [`NUM_UNITS-1:0]  unit_request,
    output logic                   illegal,
    output alu_rs1_sel_t           alu_rs1_sel,
    output alu_rs2_sel_t           alu_rs2_sel,
    output logic [11:0]            ls_offset,
    output logic [2:0]             ls_fn3,
    output logic                   ls_load,
    output logic                   ls_store,
    output logic [2:0]             branch_fn3,
    output logic                   branch_signed,
    output logic                   branch_jal,
    output logic                   branch_jalr,
    output gc_op_t                 gc_op
);

    opcode_t opcode;
    logic [2:0] fn3;
    logic valid_opcode;
    logic csr_op;

    ////////////////////
    // Fields
    assign opcode = opcode_t'(instruction[6:2]);
    assign fn3 = instruction[14:12];
    assign rs1_addr = instruction[19:15];
    assign rs2_addr = instruction[24:20];
    assign rd_addr = instruction[11:7];
    assign csr_op = (opcode == SYSTEM) && (fn3 != 3'b000);

    ////////////////////
    // Legality
    assign valid_opcode = opcode inside {LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE,
                                         ARITH, ARITH_IMM, FENCE, SYSTEM};
    // No M extension, so funct7 bit 0 on register ops is rejected
    assign illegal = ~valid_opcode || (instruction[1:0] != 2'b11) ||
                     ((opcode == ARITH) && instruction[25]);

    // Illegal instructions read and write nothing
    assign uses_rs1 = ~illegal && ((opcode inside {JALR, BRANCH, LOAD, STORE, ARITH, ARITH_IMM})
                                   || (csr_op && ~fn3[2]));
    assign uses_rs2 = ~illegal && (opcode inside {BRANCH, STORE, ARITH});
    assign uses_rd = ~illegal && ((opcode inside {LUI, AUIPC, JAL, JALR, LOAD, ARITH, ARITH_IMM})
                                  || csr_op);

    ////////////////////
    // Unit selection
    assign unit_request[UNIT_BRANCH] = ~illegal && (opcode inside {BRANCH, JAL, JALR});
    assign unit_request[UNIT_LS] = ~illegal && (opcode inside {LOAD, STORE});
    assign unit_request[UNIT_GC] = ~illegal && (opcode inside {SYSTEM, FENCE});
    assign unit_request[UNIT_ALU] = ~illegal &&
                                    ~(opcode inside {BRANCH, JAL, JALR, LOAD, STORE, SYSTEM, FENCE});

    // ALU operand sources
    always_comb begin
        case (opcode)
            LUI:             alu_rs1_sel = RS1_ZERO;
            AUIPC, JAL, JALR: alu_rs1_sel = RS1_PC;
            default:         alu_rs1_sel = RS1_REG;
        endcase
        case (opcode)
            LUI, AUIPC: alu_rs2_sel = RS2_UPPER_IMM;
            ARITH_IMM:  alu_rs2_sel = RS2_ARITH_IMM;
            JAL, JALR:  alu_rs2_sel = RS2_LINK_FOUR;
            default:    alu_rs2_sel = RS2_REG;
        endcase
    end

    ////////////////////
    // Load/store
    assign ls_load = (opcode == LOAD);
    assign ls_store = (opcode == STORE);
    // Stores split the offset around the rd field
    assign ls_offset = ls_store ? {instruction[31:25], instruction[11:7]} : instruction[31:20];
    assign ls_fn3 = fn3;

    ////////////////////
    // Branch
    assign branch_fn3 = fn3;
    // BLTU and BGEU compare unsigned
    assign branch_signed = ~(fn3 inside {3'b110, 3'b111});
    assign branch_jal = (opcode == JAL);
    assign branch_jalr = (opcode == JALR);

    ////////////////////
    // System and fence
    always_comb begin
        gc_op = GC_NONE;
        if (opcode == FENCE) begin
            gc_op = fn3[0] ? GC_IFENCE : GC_FENCE;
        end else if (csr_op) begin
            gc_op = GC_CSR;
        end else if (opcode == SYSTEM) begin
            case (instruction[21:20])
                2'b00:   gc_op = GC_ECALL;
                2'b01:   gc_op = GC_EBREAK;
                2'b10:   gc_op = GC_RET;
                default: gc_op = GC_NONE;
            endcase
        end
    end

endmodule

//--- source/issue_control.sv
/*
 * Issue control
 * Issue decision, fetch pop, per-unit issue strobes,
 * scoreboard set request and global control flush flag
 */

`timescale 1ns/1ns
`include "decode_macros.svh"

module issue_control import decode_pkg::*; (
    input  logic                   fetch_valid,
    input  logic                   gc_issue_hold,
    input  logic                   gc_fetch_flush,
    input  logic                   rs1_conflict,
    input  logic                   rs2_conflict,
    input  logic [`NUM_UNITS-1:0]  unit_request,
    input  logic                   illegal,
    input  logic                   branch_ready,
    input  logic                   alu_ready,
    input  logic                   ls_ready,
    input  logic                   gc_ready,
    input  logic                   uses_rd,
    input  logic [`REG_ADDR_W-1:0] rd_addr,
    input  gc_op_t                 gc_op,
    output logic                   fetch_pop,
    output logic                   branch_issue,
    output logic                   alu_issue,
    output logic                   ls_issue,
    output logic                   gc_issue,
    output logic                   illegal_instruction,
    output logic                   set_valid,
    output logic [`REG_ADDR_W-1:0] set_rd,
    output logic                   gc_flush_required
);

    logic issue_allowed;
    logic [`NUM_UNITS-1:0] unit_ready;
    logic [`NUM_UNITS-1:0] issue;

    assign unit_ready[UNIT_BRANCH] = branch_ready;
    assign unit_ready[UNIT_ALU] = alu_ready;
    assign unit_ready[UNIT_LS] = ls_ready;
    assign unit_ready[UNIT_GC] = gc_ready;

    // Everything but the unit's ready
    assign issue_allowed = fetch_valid && ~gc_issue_hold && ~gc_fetch_flush &&
                           ~rs1_conflict && ~rs2_conflict;

    assign issue = {`NUM_UNITS{issue_allowed}} & unit_request & unit_ready;

    assign branch_issue = issue[UNIT_BRANCH];
    assign alu_issue = issue[UNIT_ALU];
    assign ls_issue = issue[UNIT_LS];
    assign gc_issue = issue[UNIT_GC];

    // Illegal ones leave without a unit
    assign illegal_instruction = issue_allowed && illegal;
    assign fetch_pop = (|issue) || illegal_instruction;

    ////////////////////
    // Scoreboard set
    assign set_valid = (|issue) && uses_rd && (rd_addr != '0);
    assign set_rd = rd_addr;

    // Environment calls, returns and instruction fences restart fetch
    assign gc_flush_required = issue[UNIT_GC] &&
                               (gc_op inside {GC_ECALL, GC_EBREAK, GC_RET, GC_IFENCE});

endmodule

//--- source/register_file.sv
/*
 * Integer register file
 * 31 general registers, two combinational reads, one writeback port
 */

`timescale 1ns/1ns
`include "decode_macros.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    input  logic                   wb_valid,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Reads see the value before a same-cycle writeback
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- source/register_scoreboard.sv
/*
 * Register scoreboard
 * One pending bit per register, source conflict flags
 */

`timescale 1ns/1ns
`include "decode_macros.svh"

module register_scoreboard (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    input  logic                   uses_rs1,
    input  logic                   uses_rs2,
    input  logic                   set_valid,
    input  logic [`REG_ADDR_W-1:0] set_rd,
    input  logic                   wb_valid,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    output logic                   rs1_conflict,
    output logic                   rs2_conflict
);

    logic [`REG_COUNT-1:0] pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (wb_valid) begin
                pending[wb_rd] <= 1'b0;
            end
            // Issued destination overrides a writeback to the same register
            if (set_valid && (set_rd != '0)) begin
                pending[set_rd] <= 1'b1;
            end
        end
    end

    assign rs1_conflict = uses_rs1 && pending[rs1_addr];
    assign rs2_conflict = uses_rs2 && pending[rs2_addr];

endmodule
